// File: cp0_subsystem.f
+incdir+include
src/cp0_reg_pkg.sv
src/cp0_cmd_pkg.sv
src/commit_encoder.sv
src/cmd_fifo.sv
src/cp0.sv
src/cp0_subsystem.sv
bench/cp0_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the cp0 subsystem testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps --top-module cp0_tb \
    -f cp0_subsystem.f -o cp0_tb_sim &&
./obj_dir/cp0_tb_sim ||
{ echo "build or simulation ended with an error"; exit 1; }

// File: bench/cp0_tb.sv
`include "cp0_macros.svh"

module cp0_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import cp0_reg_pkg::*;
    import cp0_cmd_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int N_HOLD       = 8;    // reads issued while responses are blocked
    localparam int N_RANDOM     = 60;
    localparam int N_DIRECTED   = 120;  // upper bound on directed records and timer polls
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 200 * (N_DIRECTED + N_HOLD + N_RANDOM);
    localparam logic [31:0] SEED = 32'h09da_de94;

    localparam logic [7:0] RW_REGS [5] = '{`CP0_STATUS, `CP0_CAUSE, `CP0_EPC,
                                           `CP0_COMPARE, `CP0_INDEX};
    localparam logic [7:0] WR_REGS [4] = '{`CP0_STATUS, `CP0_CAUSE, `CP0_EPC, `CP0_INDEX};
    localparam logic [7:0] RD_REGS [8] = '{`CP0_STATUS, `CP0_CAUSE, `CP0_EPC, `CP0_COMPARE,
                                           `CP0_INDEX, `CP0_BADVADDR, `CP0_COUNT, 8'h10};
    localparam exc_code_e EXC_CODES [8] = '{ADEL, ADES, SYS, BP, RI, OV, INT, ADEL};

    typedef struct packed {
        logic [7:0]  addr;
        logic [31:0] data;
        logic [31:0] mask;  // bits that take part in the compare
    } exp_t;

    logic        clk;
    logic        resetn;
    logic        retire_valid;
    retire_t     retire;
    logic        retire_ready;
    logic [5:0]  ext_int;
    logic        rsp_valid;
    cp0_rsp_t    rsp;
    logic        rsp_ready;
    logic        int_req;
    status_t     status;
    cause_t      cause;
    logic [31:0] epc;

    exp_t        exp_q[$];
    exp_t        cur_exp;
    string       test_name;
    logic [31:0] rnd;
    logic [31:0] stall_rnd;
    logic [31:0] last_rdata;
    logic [7:0]  sel;
    int          cycle = 0;
    int          hold_until;
    int          reads_issued;
    int          rsp_seen;
    bit          random_stall;
    bit          saw_stall;

    // shadow register set
    logic [3:0]  sh_index;
    logic [31:0] sh_badvaddr;
    logic [31:0] sh_compare;
    logic [31:0] sh_epc;
    status_t     sh_status;
    cause_t      sh_cause;     // ti and ip_hw filled in on reads
    logic        sh_ti;

    cp0_subsystem dut_i (
        .clk          (clk),
        .resetn       (resetn),
        .retire_valid (retire_valid),
        .retire       (retire),
        .retire_ready (retire_ready),
        .ext_int      (ext_int),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp),
        .rsp_ready    (rsp_ready),
        .int_req      (int_req),
        .status       (status),
        .cause        (cause),
        .epc          (epc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // applies one record to the shadow set and returns read data for READ
    function automatic logic [31:0] cp0_model(input retire_t r);
        reg_access_t ra;
        exc_info_t   xi;
        cause_t      c;
        ra = r.payload.acc;
        xi = r.payload.exc_info;
        case (r.kind)
            WRITE: begin
                if (ra.addr == `CP0_INDEX) sh_index = ra.wdata[3:0];
                if (ra.addr == `CP0_STATUS) sh_status = ra.wdata & 32'h0040_ff03;
                if (ra.addr == `CP0_CAUSE) sh_cause.ip_sw = ra.wdata[9:8];
                if (ra.addr == `CP0_EPC) sh_epc = ra.wdata;
                if (ra.addr == `CP0_COMPARE) begin
                    sh_compare = ra.wdata;
                    sh_ti      = 1'b0;  // compare write acks the timer
                end
            end
            EXC: begin
                if (!sh_status.exl) begin
                    sh_cause.bd       = xi.bd;
                    sh_cause.exc_code = xi.excode;
                    sh_epc            = xi.bd ? r.pc - 32'd4 : r.pc;
                end
                if (xi.excode == ADEL || xi.excode == ADES) sh_badvaddr = xi.badvaddr;
                sh_status.exl = 1'b1;
            end
            ERET: sh_status.exl = 1'b0;
            default: begin
                c       = sh_cause;
                c.ti    = sh_ti;
                c.ip_hw = ext_int | {sh_ti, 5'b0};
                case (ra.addr)
                    `CP0_INDEX:    return {28'h0, sh_index};
                    `CP0_BADVADDR: return sh_badvaddr;
                    `CP0_COMPARE:  return sh_compare;
                    `CP0_STATUS:   return sh_status;
                    `CP0_CAUSE:    return c;
                    `CP0_EPC:      return sh_epc;
                    default:       return 32'h0;  // count and unknown addresses
                endcase
            end
        endcase
        return 32'h0;
    endfunction

    function automatic logic int_model();
        logic [7:0] pending;
        pending = {ext_int | {sh_ti, 5'b0}, sh_cause.ip_sw};
        return (|(pending & sh_status.im)) && !sh_status.exl && sh_status.ie;
    endfunction

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            stop_run($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic send_record(input cmd_kind_e kind, input logic [39:0] payload,
                               input logic [31:0] pc, input logic [31:0] mask);
        retire_t r;
        exp_t    e;
        r.kind    = kind;
        r.payload = payload;
        r.pc      = pc;
        e.addr    = r.payload.acc.addr;
        e.data    = cp0_model(r);
        e.mask    = mask;
        if (kind == READ) begin
            exp_q.push_back(e);
            reads_issued++;
        end
        retire_valid = 1'b1;
        retire       = r;
        @(negedge clk);
        while (!retire_ready) begin  // out of credits
            saw_stall = 1'b1;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        retire_valid = 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        send_record(WRITE, {addr, data}, 32'h0000_0400, 32'h0);
    endtask

    task automatic read_reg(input logic [7:0] addr, input logic [31:0] mask = '1);
        send_record(READ, {addr, 32'h0}, 32'h0000_0404, addr == `CP0_COUNT ? 32'h0 : mask);
    endtask

    task automatic take_exc(input exc_code_e code, input logic bd,
                            input logic [31:0] badvaddr, input logic [31:0] pc);
        send_record(EXC, {code, bd, 2'b00, badvaddr}, pc, 32'h0);
    endtask

    task automatic return_from_exc();
        send_record(ERET, 40'h0, 32'h0000_0408, 32'h0);
    endtask

    // wait until every issued read has been answered
    task automatic drain();
        @(posedge clk);
        while (rsp_seen != reads_issued) @(posedge clk);
        #1;
    endtask

    // status, cause and epc ports against the shadow set
    task automatic check_views();
        cause_t c;
        c       = sh_cause;
        c.ti    = sh_ti;
        c.ip_hw = ext_int | {sh_ti, 5'b0};
        check_value({test_name, " status"}, sh_status, status);
        check_value({test_name, " cause"}, c, cause);
        check_value({test_name, " epc"}, sh_epc, epc);
    endtask

    task automatic check_int_after_read();
        read_reg(`CP0_CAUSE);
        drain();
        check_value({test_name, " int_req"}, 32'(int_model()), 32'(int_req));
        check_views();
    endtask

    initial begin
        rsp_ready = 1'b0;
        stall_rnd = xorshift(SEED ^ 32'h5a5a_5a5a);
        forever begin
            @(posedge clk);
            #1;
            stall_rnd = xorshift(stall_rnd);
            if (cycle < hold_until) rsp_ready = 1'b0;
            else rsp_ready = !random_stall || stall_rnd[1:0] != 2'b00;
        end
    end

    always @(negedge clk) begin
        if (resetn && rsp_valid && rsp_ready) begin
            if (exp_q.size() == 0) begin
                stop_run("a read response arrived with no read outstanding");
            end else begin
                cur_exp = exp_q.pop_front();
                check_value({test_name, " addr"}, 32'(cur_exp.addr), 32'(rsp.addr));
                check_value(test_name, cur_exp.data & cur_exp.mask, rsp.rdata & cur_exp.mask);
                last_rdata = rsp.rdata;
                rsp_seen++;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_run("timeout, the tests did not finish within the cycle budget");
    end

    initial begin
        resetn       = 1'b0;
        retire_valid = 1'b0;
        retire       = '0;
        ext_int      = '0;
        hold_until   = 0;
        reads_issued = 0;
        rsp_seen     = 0;
        random_stall = 1'b0;
        saw_stall    = 1'b0;
        rnd          = SEED;
        sh_index     = '0;
        sh_badvaddr  = '0;
        sh_compare   = 32'hffff_ffff;
        sh_epc       = '0;
        sh_status    = 32'h0040_0000;  // bev only
        sh_cause     = '0;
        sh_ti        = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        resetn = 1'b1;

        test_name = "reset";
        check_value("reset retire_ready", 32'd1, 32'(retire_ready));
        check_value("reset rsp_valid", 32'd0, 32'(rsp_valid));
        check_value("reset int_req", 32'd0, 32'(int_req));

        test_name = "write_read";
        repeat (3) begin
            foreach (RW_REGS[i]) begin
                rnd = xorshift(rnd);
                // compare kept far above count
                write_reg(RW_REGS[i], RW_REGS[i] == `CP0_COMPARE ? rnd | 32'h8000_0000 : rnd);
                read_reg(RW_REGS[i]);
            end
        end
        write_reg(`CP0_STATUS, 32'h0);
        write_reg(`CP0_CAUSE, 32'h0);
        drain();

        test_name = "exception";
        take_exc(SYS, 1'b1, 32'h0, 32'h0000_1004);  // delay slot
        read_reg(`CP0_CAUSE);
        read_reg(`CP0_EPC);
        read_reg(`CP0_STATUS);
        return_from_exc();
        read_reg(`CP0_STATUS);
        take_exc(ADES, 1'b0, 32'hdead_beef, 32'h0000_2000);
        read_reg(`CP0_BADVADDR);
        read_reg(`CP0_CAUSE);
        read_reg(`CP0_EPC);
        take_exc(BP, 1'b1, 32'h1234_5678, 32'h0000_3008);  // nested
        read_reg(`CP0_CAUSE);
        read_reg(`CP0_EPC);
        read_reg(`CP0_BADVADDR);
        return_from_exc();
        read_reg(`CP0_STATUS);
        drain();

        test_name = "interrupt";
        ext_int = 6'b000100;  // ip_hw[2], im bit 4
        repeat (2) @(posedge clk);
        #1;
        write_reg(`CP0_STATUS, 32'h0000_1001);
        check_int_after_read();
        write_reg(`CP0_STATUS, 32'h0000_0001);
        check_int_after_read();
        write_reg(`CP0_STATUS, 32'h0000_1001);
        check_int_after_read();
        take_exc(OV, 1'b0, 32'h0, 32'h0000_4000);
        check_int_after_read();
        return_from_exc();
        check_int_after_read();
        write_reg(`CP0_STATUS, 32'h0);
        drain();
        ext_int = '0;
        repeat (2) @(posedge clk);
        #1;

        test_name = "backpressure";
        saw_stall  = 1'b0;
        hold_until = cycle + 40;
        for (int i = 0; i < N_HOLD; i++) read_reg(RD_REGS[i]);
        check_value("backpressure retire_ready fell", 32'd1, 32'(saw_stall));
        drain();

        test_name    = "random";
        random_stall = 1'b1;
        repeat (N_RANDOM) begin
            rnd = xorshift(rnd);
            sel = rnd[7:0];
            rnd = xorshift(rnd);
            case (sel[2:0])
                3'd0, 3'd1: write_reg(WR_REGS[sel[4:3]], rnd);
                3'd5:       take_exc(EXC_CODES[sel[5:3]], sel[6], rnd,
                                     {16'h0, rnd[15:2], 2'b00});
                3'd6:       return_from_exc();
                default:    read_reg(RD_REGS[sel[5:3]]);
            endcase
        end
        drain();
        random_stall = 1'b0;

        test_name = "timer";
        write_reg(`CP0_COUNT, 32'h0000_0100);
        write_reg(`CP0_COMPARE, 32'h0000_0118);
        do begin
            read_reg(`CP0_CAUSE, ~32'h4000_8000);  // ti and timer ip still moving
            drain();
        end while (!last_rdata[30]);
        sh_ti = 1'b1;
        read_reg(`CP0_CAUSE, ~32'h0000_8000);  // ti holds until Compare is written
        write_reg(`CP0_COMPARE, 32'h8000_0000);
        read_reg(`CP0_CAUSE, ~32'h0000_8000);  // ip_hw lags ti by a cycle
        read_reg(`CP0_COMPARE);
        drain();
        check_views();

        $display("Simulation passed");
        $finish;
    end

endmodule

// File: src/cp0_subsystem.sv
module cp0_subsystem (
    input  logic                  clk,
    input  logic                  resetn,

    // retire port from the pipeline
    input  logic                  retire_valid,
    input  cp0_cmd_pkg::retire_t  retire,
    output logic                  retire_ready,

    input  logic [5:0]            ext_int,

    // mfc0 results
    output logic                  rsp_valid,
    output cp0_cmd_pkg::cp0_rsp_t rsp,
    input  logic                  rsp_ready,

    output logic                  int_req,
    output cp0_reg_pkg::status_t  status,
    output cp0_reg_pkg::cause_t   cause,
    output logic [31:0]           epc
);
    import cp0_cmd_pkg::*;

    logic     push;
    cp0_cmd_t cmd;
    logic     credit_return;
    logic     head_valid;
    cp0_cmd_t head;
    logic     pop;

    commit_encoder u_encoder (
        .clk           (clk),
        .resetn        (resetn),
        .retire_valid  (retire_valid),
        .retire        (retire),
        .retire_ready  (retire_ready),
        .push          (push),
        .cmd           (cmd),
        .credit_return (credit_return)
    );

    cmd_fifo u_fifo (
        .clk           (clk),
        .resetn        (resetn),
        .push          (push),
        .cmd           (cmd),
        .pop           (pop),
        .head_valid    (head_valid),
        .head          (head),
        .credit_return (credit_return)
    );

    cp0 u_cp0 (
        .clk        (clk),
        .resetn     (resetn),
        .ext_int    (ext_int),
        .head_valid (head_valid),
        .head       (head),
        .pop        (pop),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .rsp_ready  (rsp_ready),
        .int_req    (int_req),
        .status     (status),
        .cause      (cause),
        .epc        (epc)
    );

endmodule

// File: src/cp0.sv
`include "cp0_macros.svh"

module cp0 (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [5:0]            ext_int,
    input  logic                  head_valid,
    input  cp0_cmd_pkg::cp0_cmd_t head,
    output logic                  pop,
    output logic                  rsp_valid,
    output cp0_cmd_pkg::cp0_rsp_t rsp,
    input  logic                  rsp_ready,
    output logic                  int_req,
    output cp0_reg_pkg::status_t  status,
    output cp0_reg_pkg::cause_t   cause,
    output logic [31:0]           epc
);
    import cp0_reg_pkg::*;
    import cp0_cmd_pkg::*;

    reg_access_t          ra;
    exc_info_t            xi;
    status_t              status_wr;
    logic                 do_wr, do_rd, do_exc, do_eret;
    logic                 rsp_free;
    logic [`INDEX_W-1:0]  index_q;
    logic [31:0]          badvaddr, count, compare;
    logic                 tick, timer_int;
    status_t              status_q;
    logic                 cause_bd;
    logic [HW_INT_W-1:0]  ip_hw;
    logic [1:0]           ip_sw;
    exc_code_e            exc_code;
    logic [31:0]          rdata;

    // same payload word, two readings
    assign ra        = head.payload.acc;
    assign xi        = head.payload.exc_info;
    assign status_wr = ra.wdata;

    // a read needs somewhere to park its result
    assign rsp_free = !rsp_valid || rsp_ready;
    assign pop      = head_valid && (head.kind != READ || rsp_free);

    assign do_wr   = pop && head.kind == WRITE;
    assign do_rd   = pop && head.kind == READ;
    assign do_exc  = pop && head.kind == EXC;
    assign do_eret = pop && head.kind == ERET;

    // Count ticks at half the core clock
    always_ff @(posedge clk) begin
        if (!resetn) begin
            tick      <= 1'b0;
            count     <= `COUNT_RESET;
            compare   <= `COMPARE_RESET;
            timer_int <= 1'b0;
        end else begin
            tick <= ~tick;
            if (do_wr && ra.addr == `CP0_COUNT) count <= ra.wdata;
            else if (tick) count <= count + 32'd1;
            if (do_wr && ra.addr == `CP0_COMPARE) begin
                compare   <= ra.wdata;
                timer_int <= 1'b0;  // writing Compare acks the timer
            end else if (count == compare) begin
                timer_int <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            status_q <= STATUS_RESET;
        end else if (do_exc) begin
            status_q.exl <= 1'b1;
        end else if (do_eret) begin
            status_q.exl <= 1'b0;
        end else if (do_wr && ra.addr == `CP0_STATUS) begin
            status_q.bev <= status_wr.bev;
            status_q.im  <= status_wr.im;
            status_q.exl <= status_wr.exl;
            status_q.ie  <= status_wr.ie;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cause_bd <= 1'b0;
            exc_code <= INT;
            ip_hw    <= '0;
            ip_sw    <= '0;
        end else begin
            ip_hw <= ext_int | {timer_int, 5'b0};  // timer on ip_hw[TIMER_IP]
            if (do_wr && ra.addr == `CP0_CAUSE) ip_sw <= ra.wdata[9:8];
            // nested exception keeps the first one's state
            if (do_exc && !status_q.exl) begin
                cause_bd <= xi.bd;
                exc_code <= xi.excode;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            index_q  <= '0;
            badvaddr <= '0;
            epc      <= '0;
        end else begin
            if (do_wr && ra.addr == `CP0_INDEX) index_q <= ra.wdata[`INDEX_W-1:0];
            if (do_exc && (xi.excode == ADEL || xi.excode == ADES)) begin
                badvaddr <= xi.badvaddr;
            end
            if (do_exc && !status_q.exl) epc <= head.epc;
            else if (do_wr && ra.addr == `CP0_EPC) epc <= ra.wdata;
        end
    end

    assign status = status_q;

    always_comb begin
        cause          = '0;
        cause.bd       = cause_bd;
        cause.ti       = timer_int;
        cause.ip_hw    = ip_hw;
        cause.ip_sw    = ip_sw;
        cause.exc_code = exc_code;
    end

    // pending and unmasked, not already in a handler, globally on
    assign int_req = |({cause.ip_hw, cause.ip_sw} & status_q.im)
                     && !status_q.exl && status_q.ie;

    always_comb begin
        case (ra.addr)
            `CP0_INDEX:    rdata = {1'b0, {(31 - `INDEX_W){1'b0}}, index_q};  // P stays 0
            `CP0_BADVADDR: rdata = badvaddr;
            `CP0_COUNT:    rdata = count;
            `CP0_COMPARE:  rdata = compare;
            `CP0_STATUS:   rdata = status_q;
            `CP0_CAUSE:    rdata = cause;
            `CP0_EPC:      rdata = epc;
            default:       rdata = '0;
        endcase
    end

    // response held until the outside takes it
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rsp_valid <= 1'b0;
        end else if (do_rd) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (do_rd) begin
            rsp.addr  <= ra.addr;
            rsp.rdata <= rdata;
        end
    end

endmodule

// File: src/cmd_fifo.sv
`include "cp0_macros.svh"

module cmd_fifo (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  push,
    input  cp0_cmd_pkg::cp0_cmd_t cmd,
    input  logic                  pop,
    output logic                  head_valid,
    output cp0_cmd_pkg::cp0_cmd_t head,
    output logic                  credit_return
);
    import cp0_cmd_pkg::*;

    localparam int DEPTH = `CMD_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    cp0_cmd_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] used;
    logic             do_pop;

    // wrap explicitly, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign head_valid = used != '0;
    assign head       = mem[rd_ptr];
    assign do_pop     = pop && head_valid;

    // no full check, the encoder only pushes on a held credit
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            used          <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push) wr_ptr <= ptr_next(wr_ptr);
            if (do_pop) rd_ptr <= ptr_next(rd_ptr);
            case ({push, do_pop})
                2'b10:   used <= used + 1'b1;
                2'b01:   used <= used - 1'b1;
                default: used <= used;
            endcase
            credit_return <= do_pop;  // one pulse per freed slot
        end
    end

endmodule

// File: src/commit_encoder.sv
`include "cp0_macros.svh"

module commit_encoder (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  retire_valid,
    input  cp0_cmd_pkg::retire_t  retire,
    output logic                  retire_ready,
    output logic                  push,
    output cp0_cmd_pkg::cp0_cmd_t cmd,
    input  logic                  credit_return
);
    import cp0_cmd_pkg::*;

    localparam logic [`CREDIT_W-1:0] CREDIT_INIT = `CMD_DEPTH;

    logic [`CREDIT_W-1:0] credits;  // free queue slots not yet claimed
    logic                 take;
    logic [31:0]          epc_next;

    assign take         = retire_valid && retire_ready;
    assign retire_ready = credits != '0;

    // exception in a delay slot points back at the branch
    always_comb begin
        epc_next = retire.pc;
        if (retire.kind == EXC && retire.payload.exc_info.bd) begin
            epc_next = retire.pc - 32'd4;
        end
    end

    // credit is claimed on acceptance, so the push that follows
    // always has a slot waiting for it
    always_ff @(posedge clk) begin
        if (!resetn) begin
            credits <= CREDIT_INIT;
        end else begin
            case ({take, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;  // none or both
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            push <= 1'b0;
        end else begin
            push <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            cmd.kind    <= retire.kind;
            cmd.payload <= retire.payload;  // untouched
            cmd.epc     <= epc_next;
        end
    end

endmodule

// File: src/cp0_cmd_pkg.sv
package cp0_cmd_pkg;

    typedef enum logic [1:0] {
        WRITE = 2'd0,  // mtc0
        READ  = 2'd1,  // mfc0
        EXC   = 2'd2,  // exception taken
        ERET  = 2'd3
    } cmd_kind_e;

    // mtc0 / mfc0 view of the payload
    typedef struct packed {
        logic [7:0]  addr;
        logic [31:0] wdata;   // ignored for READ
    } reg_access_t;

    // exception view of the payload
    typedef struct packed {
        cp0_reg_pkg::exc_code_e excode;
        logic                   bd;
        logic [1:0]             spare;
        logic [31:0]            badvaddr;  // only meaningful for ADEL/ADES
    } exc_info_t;

    // one 40 bit word, meaning picked by kind
    typedef union packed {
        reg_access_t acc;
        exc_info_t   exc_info;
    } cmd_payload_u;

    // record retired by the pipeline
    typedef struct packed {
        cmd_kind_e    kind;
        cmd_payload_u payload;
        logic [31:0]  pc;
    } retire_t;

    // command as it sits in the queue
    typedef struct packed {
        cmd_kind_e    kind;
        cmd_payload_u payload;
        logic [31:0]  epc;    // already corrected for bd
    } cp0_cmd_t;

    // mfc0 result
    typedef struct packed {
        logic [7:0]  addr;
        logic [31:0] rdata;
    } cp0_rsp_t;

endpackage

// File: src/cp0_reg_pkg.sv
package cp0_reg_pkg;

    // exception codes as loaded into Cause.ExcCode
    typedef enum logic [4:0] {
        INT  = 5'd0,   // interrupt
        ADEL = 5'd4,   // address error, load or fetch
        ADES = 5'd5,   // address error, store
        SYS  = 5'd8,   // syscall
        BP   = 5'd9,   // break
        RI   = 5'd10,  // reserved instruction
        OV   = 5'd12   // arithmetic overflow
    } exc_code_e;

    // Status, reg 12
    typedef struct packed {
        logic [8:0] zero_31_23;
        logic       bev;         // 22, boot vectors
        logic [5:0] zero_21_16;
        logic [7:0] im;          // 15:8, interrupt mask
        logic [5:0] zero_7_2;
        logic       exl;         // 1, exception level
        logic       ie;          // 0, global enable
    } status_t;

    // Cause, reg 13
    typedef struct packed {
        logic       bd;          // 31, branch delay slot
        logic       ti;          // 30, timer pending
        logic [13:0] zero_29_16;
        logic [5:0] ip_hw;       // 15:10, hardware pending
        logic [1:0] ip_sw;       // 9:8, software pending
        logic       zero_7;
        exc_code_e  exc_code;    // 6:2
        logic [1:0] zero_1_0;
    } cause_t;

    // hardware interrupt lines, the timer sits on the top one
    localparam int HW_INT_W = 6;
    localparam int TIMER_IP = 5;

    // Status reset image, only bev is set
    localparam status_t STATUS_RESET = '{
        zero_31_23: '0,
        bev:        1'b1,
        zero_21_16: '0,
        im:         '0,
        zero_7_2:   '0,
        exl:        1'b0,
        ie:         1'b0
    };

endpackage

// File: include/cp0_macros.svh
`ifndef CP0_MACROS_SVH
`define CP0_MACROS_SVH

// cp0 register addresses, {reg[4:0], sel[2:0]}
`define CP0_INDEX     8'h00  // reg 0
`define CP0_BADVADDR  8'h40  // reg 8
`define CP0_COUNT     8'h48  // reg 9
`define CP0_COMPARE   8'h58  // reg 11
`define CP0_STATUS    8'h60  // reg 12
`define CP0_CAUSE     8'h68  // reg 13
`define CP0_EPC       8'h70  // reg 14

// writable low bits of Index
`define INDEX_W       4

// command queue between encoder and cp0
`define CMD_DEPTH     4

// credit counter must hold 0..CMD_DEPTH
`define CREDIT_W      3

// Count and Compare reset values
// compare starts far away so the timer stays quiet after reset
`define COUNT_RESET   32'h0000_0000
`define COMPARE_RESET 32'hffff_ffff

`endif
